// File: verilog/plic_pkg.sv
// Single-target PLIC definitions; register map assumes at most 32 sources below 0x080
package plic_pkg;

  ////////////////////////////////////////////////////
  // AXI4-Lite bus widths and response codes
  ////////////////////////////////////////////////////

  // The address covers the whole 4 KiB register window
  localparam int AXIL_ADDR_W = 12;
  localparam int AXIL_DATA_W = 32;

  // Only the two codes the slave can ever return are listed
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  // Slave handshake state, one transaction in flight at most
  typedef enum logic [1:0] {
    AXI_IDLE  = 2'b00,
    AXI_WRESP = 2'b01,
    AXI_RDATA = 2'b10
  } axil_state_e;

  ////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////

  // Decoded class of an incoming address
  typedef enum logic [2:0] {
    SEL_PRIO      = 3'd0,
    SEL_PENDING   = 3'd1,
    SEL_ENABLE    = 3'd2,
    SEL_THRESHOLD = 3'd3,
    SEL_CLAIM     = 3'd4,
    SEL_NONE      = 3'd5
  } reg_sel_e;

  // Priority of ID n sits at PRIO_BASE + 4*(n-1)
  localparam logic [AXIL_ADDR_W-1:0] PRIO_BASE      = 12'h000;
  localparam logic [AXIL_ADDR_W-1:0] PENDING_ADDR   = 12'h080;
  localparam logic [AXIL_ADDR_W-1:0] ENABLE_ADDR    = 12'h100;
  localparam logic [AXIL_ADDR_W-1:0] THRESHOLD_ADDR = 12'h200;
  localparam logic [AXIL_ADDR_W-1:0] CLAIM_ADDR     = 12'h204;

endpackage

// File: verilog/plic_cfg_if.sv
// Internal PLIC bundle; widths must match the NumSrc and PrioWidth of every attached block
`timescale 1ns/1ns

interface plic_cfg_if #(
  parameter int NumSrc    = 8,
  parameter int PrioWidth = 3
);

  // ID 0 is reserved for no interrupt, so one extra code is needed
  localparam int IdWidth = $clog2(NumSrc + 1);

  // Configuration written over the bus
  logic [NumSrc-1:0][PrioWidth-1:0] prio;
  logic [NumSrc-1:0]                enable;
  logic [PrioWidth-1:0]             threshold;

  // Live interrupt state
  logic [NumSrc-1:0]                pending;
  logic [IdWidth-1:0]               best_id;

  // One-cycle events from the claim/complete register
  logic                             claim_valid;
  logic [IdWidth-1:0]               claim_id;
  logic                             complete_valid;
  logic [IdWidth-1:0]               complete_id;

  modport regs (
    output prio, enable, threshold,
    output claim_valid, claim_id, complete_valid, complete_id,
    input  pending, best_id
  );

  modport gateway (
    input  claim_valid, claim_id, complete_valid, complete_id,
    output pending
  );

  modport target (
    input  prio, enable, threshold, pending,
    output best_id
  );

endinterface

// File: verilog/plic_max_tree.sv
// Purely combinational max search; needs NumSrc >= 2, ties resolve to the lowest index
`timescale 1ns/1ns

module plic_max_tree #(
  parameter int NumSrc    = 8,
  parameter int PrioWidth = 3
) (
  // Clock has no role in the combinational search
  input  logic                             clk_i,
  input  logic [NumSrc-1:0][PrioWidth-1:0] values_i,
  input  logic [NumSrc-1:0]                valid_i,
  output logic [PrioWidth-1:0]             max_value_o,
  output logic [$clog2(NumSrc)-1:0]        max_idx_o,
  output logic                             max_valid_o
);

  localparam int SrcWidth  = $clog2(NumSrc);
  // Leaves are padded up to the next power of two
  localparam int NumLeaves = 2 ** SrcWidth;
  localparam int NumNodes  = 2 * NumLeaves - 1;
  // Heap numbering puts the first leaf right after the last inner node
  localparam int FirstLeaf = NumLeaves - 1;

  logic [NumNodes-1:0]                node_vld;
  logic [NumNodes-1:0][SrcWidth-1:0]  node_idx;
  logic [NumNodes-1:0][PrioWidth-1:0] node_val;

  if (NumSrc < 2) begin : gen_bad_num_src
    $error("plic_max_tree needs at least two sources");
  end

  //////////////////////////////////////////////////
  // Tree nodes, root at 0, children at 2n+1, 2n+2
  //////////////////////////////////////////////////

  always_comb begin
    // Leaves beyond NumSrc keep the all-zero tie-off and are never valid
    node_vld = '0;
    node_idx = '0;
    node_val = '0;
    for (int l = 0; l < NumSrc; l++) begin
      node_vld[FirstLeaf+l] = valid_i[l];
      node_idx[FirstLeaf+l] = SrcWidth'(l);
      node_val[FirstLeaf+l] = values_i[l];
    end
    // Children always carry higher numbers, so walking down fills them before the parent
    for (int n = FirstLeaf - 1; n >= 0; n--) begin
      logic take_right;
      // The left child always covers the lower indices, so it keeps ties
      // With neither child valid the left one still passes, leaving index 0 at the root
      take_right  = node_vld[2*n+2] &
                    (~node_vld[2*n+1] | (node_val[2*n+2] > node_val[2*n+1]));
      node_vld[n] = take_right ? node_vld[2*n+2] : node_vld[2*n+1];
      node_idx[n] = take_right ? node_idx[2*n+2] : node_idx[2*n+1];
      node_val[n] = take_right ? node_val[2*n+2] : node_val[2*n+1];
    end
  end

  assign max_valid_o = node_vld[0];
  assign max_idx_o   = node_idx[0];
  assign max_value_o = node_val[0];

endmodule

// File: verilog/plic_gateway.sv
// Level-only gateway; sources must already be synchronous to clk_i
`timescale 1ns/1ns

module plic_gateway #(
  parameter int NumSrc    = 8,
  parameter int PrioWidth = 3
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [NumSrc-1:0] src_i,
  plic_cfg_if.gateway       cfg
);

  localparam int IdWidth = $clog2(NumSrc + 1);

  // Priority width is only carried for the interface, the gateway never looks at it
  localparam int UnusedPrioWidth = PrioWidth;

  logic [NumSrc-1:0] pending_q;
  logic [NumSrc-1:0] in_service_q;
  logic [NumSrc-1:0] claim_hit;
  logic [NumSrc-1:0] complete_hit;

  // Turn the claim and complete IDs into one-hot source masks
  // ID n maps to bit n-1, ID 0 hits nothing
  always_comb begin
    for (int i = 0; i < NumSrc; i++) begin
      claim_hit[i]    = cfg.claim_valid & (cfg.claim_id == IdWidth'(i + 1));
      // Completing a source that is not in service does nothing
      complete_hit[i] = cfg.complete_valid & (cfg.complete_id == IdWidth'(i + 1)) &
                        in_service_q[i];
    end
  end

  //////////////////////////////////////////////////
  // Pending and in-service state
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q    <= '0;
      in_service_q <= '0;
    end else begin
      // A high level raises pending unless the source is still being served
      // The claimed bit is dropped on the same edge it moves to in service
      pending_q    <= (pending_q | (src_i & ~in_service_q)) & ~claim_hit;
      in_service_q <= (in_service_q | (claim_hit & pending_q)) & ~complete_hit;
    end
  end

  assign cfg.pending = pending_q;

  // Elaboration guard, keeps the width sane for the interface
  if (UnusedPrioWidth < 1) begin : gen_bad_prio
    $error("plic_gateway needs a priority width of at least one");
  end

endmodule

// File: verilog/plic_target.sv
// Single interrupt target; irq_o follows pending or configuration changes by one cycle
`timescale 1ns/1ns

module plic_target #(
  parameter int NumSrc    = 8,
  parameter int PrioWidth = 3
) (
  input  logic       clk_i,
  input  logic       rst_i,
  plic_cfg_if.target cfg,
  output logic       irq_o
);

  localparam int IdWidth  = $clog2(NumSrc + 1);
  localparam int SrcWidth = $clog2(NumSrc);

  logic [NumSrc-1:0]    eligible;
  logic [PrioWidth-1:0] win_prio;
  logic [SrcWidth-1:0]  win_idx;
  logic                 win_valid;
  logic [IdWidth-1:0]   best_id_q;

  // A source competes only if pending, enabled and given a nonzero priority
  always_comb begin
    for (int i = 0; i < NumSrc; i++) begin
      eligible[i] = cfg.pending[i] & cfg.enable[i] & (|cfg.prio[i]);
    end
  end

  plic_max_tree #(
    .NumSrc    (NumSrc),
    .PrioWidth (PrioWidth)
  ) u_max_tree (
    .clk_i       (clk_i),
    .values_i    (cfg.prio),
    .valid_i     (eligible),
    .max_value_o (win_prio),
    .max_idx_o   (win_idx),
    .max_valid_o (win_valid)
  );

  //////////////////////////////////////////////////
  // Winner register
  //////////////////////////////////////////////////

  // The winner has to beat the threshold strictly, otherwise ID 0 is held
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      best_id_q <= '0;
    end else if (win_valid && (win_prio > cfg.threshold)) begin
      best_id_q <= IdWidth'(win_idx) + IdWidth'(1);
    end else begin
      best_id_q <= '0;
    end
  end

  assign cfg.best_id = best_id_q;
  // Any nonzero ID is an interrupt worth taking
  assign irq_o       = |best_id_q;

endmodule

// File: verilog/plic_axil_regs.sv
// AXI4-Lite register slave; full-word writes only, no strobes, one transaction at a time
`timescale 1ns/1ns

module plic_axil_regs import plic_pkg::*; #(
  parameter int NumSrc    = 8,
  parameter int PrioWidth = 3
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  plic_cfg_if.regs               cfg,
  // Write address channel
  input  logic [AXIL_ADDR_W-1:0] s_awaddr_i,
  input  logic                   s_awvalid_i,
  output logic                   s_awready_o,
  // Write data channel
  input  logic [AXIL_DATA_W-1:0] s_wdata_i,
  input  logic                   s_wvalid_i,
  output logic                   s_wready_o,
  // Write response channel
  output logic [1:0]             s_bresp_o,
  output logic                   s_bvalid_o,
  input  logic                   s_bready_i,
  // Read address channel
  input  logic [AXIL_ADDR_W-1:0] s_araddr_i,
  input  logic                   s_arvalid_i,
  output logic                   s_arready_o,
  // Read data channel
  output logic [AXIL_DATA_W-1:0] s_rdata_o,
  output logic [1:0]             s_rresp_o,
  output logic                   s_rvalid_o,
  input  logic                   s_rready_i
);

  localparam int IdWidth  = $clog2(NumSrc + 1);
  localparam int SrcWidth = $clog2(NumSrc);

  axil_state_e                      state_q;
  logic [NumSrc-1:0][PrioWidth-1:0] prio_q;
  logic [NumSrc-1:0]                enable_q;
  logic [PrioWidth-1:0]             threshold_q;
  axil_resp_e                       bresp_q;
  axil_resp_e                       rresp_q;
  logic [AXIL_DATA_W-1:0]           rdata_q;
  logic                             wr_fire;
  logic                             rd_fire;
  reg_sel_e                         wr_sel;
  reg_sel_e                         rd_sel;
  logic [SrcWidth-1:0]              wr_idx;
  logic [SrcWidth-1:0]              rd_idx;
  logic [AXIL_DATA_W-1:0]           rd_word;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  // Misaligned addresses never hit a register
  function automatic reg_sel_e decode(input logic [AXIL_ADDR_W-1:0] addr);
    logic [AXIL_ADDR_W-1:0] prio_off;
    prio_off = addr - PRIO_BASE;
    if (addr[1:0] != 2'b00) begin
      return SEL_NONE;
    end
    if (prio_off < AXIL_ADDR_W'(4 * NumSrc)) begin
      return SEL_PRIO;
    end
    case (addr)
      PENDING_ADDR:   return SEL_PENDING;
      ENABLE_ADDR:    return SEL_ENABLE;
      THRESHOLD_ADDR: return SEL_THRESHOLD;
      CLAIM_ADDR:     return SEL_CLAIM;
      default:        return SEL_NONE;
    endcase
  endfunction

  // Word index into the priority array, meaningful only for SEL_PRIO
  function automatic logic [SrcWidth-1:0] prio_index(input logic [AXIL_ADDR_W-1:0] addr);
    logic [AXIL_ADDR_W-1:0] off;
    off = addr - PRIO_BASE;
    return off[2 +: SrcWidth];
  endfunction

  assign wr_sel = decode(s_awaddr_i);
  assign rd_sel = decode(s_araddr_i);
  assign wr_idx = prio_index(s_awaddr_i);
  assign rd_idx = prio_index(s_araddr_i);

  // Both write channels must be present; a write beats a read in the same cycle
  assign wr_fire = (state_q == AXI_IDLE) & s_awvalid_i & s_wvalid_i;
  assign rd_fire = (state_q == AXI_IDLE) & s_arvalid_i & ~(s_awvalid_i & s_wvalid_i);

  assign s_awready_o = wr_fire;
  assign s_wready_o  = wr_fire;
  assign s_arready_o = rd_fire;

  // Read data mux, sampled at acceptance so the claim returns the current winner
  always_comb begin
    case (rd_sel)
      SEL_PRIO:      rd_word = AXIL_DATA_W'(prio_q[rd_idx]);
      SEL_PENDING:   rd_word = AXIL_DATA_W'(cfg.pending);
      SEL_ENABLE:    rd_word = AXIL_DATA_W'(enable_q);
      SEL_THRESHOLD: rd_word = AXIL_DATA_W'(threshold_q);
      SEL_CLAIM:     rd_word = AXIL_DATA_W'(cfg.best_id);
      default:       rd_word = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Handshake FSM and configuration registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= AXI_IDLE;
      prio_q      <= '0;
      enable_q    <= '0;
      threshold_q <= '0;
    end else begin
      case (state_q)
        AXI_IDLE: begin
          if (wr_fire) begin
            state_q <= AXI_WRESP;
            // Pending is read only and the claim write is handled as an event
            case (wr_sel)
              SEL_PRIO:      prio_q[wr_idx] <= s_wdata_i[PrioWidth-1:0];
              SEL_ENABLE:    enable_q       <= s_wdata_i[NumSrc-1:0];
              SEL_THRESHOLD: threshold_q    <= s_wdata_i[PrioWidth-1:0];
              default:       ;
            endcase
          end else if (rd_fire) begin
            state_q <= AXI_RDATA;
          end
        end
        // Hold the response until the master takes it
        AXI_WRESP: if (s_bready_i) state_q <= AXI_IDLE;
        AXI_RDATA: if (s_rready_i) state_q <= AXI_IDLE;
        default:   state_q <= AXI_IDLE;
      endcase
    end
  end

  // Response payload only moves at acceptance, so it stays put under back-pressure
  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      bresp_q <= (wr_sel == SEL_NONE) ? RESP_SLVERR : RESP_OKAY;
    end
    if (rd_fire) begin
      rdata_q <= rd_word;
      rresp_q <= (rd_sel == SEL_NONE) ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign s_bvalid_o = (state_q == AXI_WRESP);
  assign s_bresp_o  = bresp_q;
  assign s_rvalid_o = (state_q == AXI_RDATA);
  assign s_rresp_o  = rresp_q;
  assign s_rdata_o  = rdata_q;

  // Configuration out to the gateway and target
  assign cfg.prio      = prio_q;
  assign cfg.enable    = enable_q;
  assign cfg.threshold = threshold_q;

  // Reading the claim register takes the winner; an empty claim does nothing
  assign cfg.claim_valid    = rd_fire & (rd_sel == SEL_CLAIM) & (cfg.best_id != '0);
  assign cfg.claim_id       = cfg.best_id;
  // Writing an ID back to the claim register completes it
  assign cfg.complete_valid = wr_fire & (wr_sel == SEL_CLAIM);
  assign cfg.complete_id    = s_wdata_i[IdWidth-1:0];

endmodule

// File: verilog/plic_top.sv
// PLIC top level; one target, level sources synchronous to clk_i, NumSrc from 2 to 32
`timescale 1ns/1ns

module plic_top import plic_pkg::*; #(
  parameter int NumSrc    = 8,
  parameter int PrioWidth = 3
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic [NumSrc-1:0]      src_i,
  output logic                   irq_o,
  // AXI4-Lite slave
  input  logic [AXIL_ADDR_W-1:0] s_awaddr_i,
  input  logic                   s_awvalid_i,
  output logic                   s_awready_o,
  input  logic [AXIL_DATA_W-1:0] s_wdata_i,
  input  logic                   s_wvalid_i,
  output logic                   s_wready_o,
  output logic [1:0]             s_bresp_o,
  output logic                   s_bvalid_o,
  input  logic                   s_bready_i,
  input  logic [AXIL_ADDR_W-1:0] s_araddr_i,
  input  logic                   s_arvalid_i,
  output logic                   s_arready_o,
  output logic [AXIL_DATA_W-1:0] s_rdata_o,
  output logic [1:0]             s_rresp_o,
  output logic                   s_rvalid_o,
  input  logic                   s_rready_i
);

  // Shared bundle between the three blocks
  plic_cfg_if #(.NumSrc(NumSrc), .PrioWidth(PrioWidth)) u_cfg_if ();

  // Input side
  plic_gateway #(.NumSrc(NumSrc), .PrioWidth(PrioWidth)) u_gateway (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .src_i (src_i),
    .cfg   (u_cfg_if.gateway)
  );

  // Arbitration and interrupt line
  plic_target #(.NumSrc(NumSrc), .PrioWidth(PrioWidth)) u_target (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .cfg   (u_cfg_if.target),
    .irq_o (irq_o)
  );

  // Bus side, configuration in and claim out
  plic_axil_regs #(.NumSrc(NumSrc), .PrioWidth(PrioWidth)) u_axil_regs (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cfg         (u_cfg_if.regs),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_bresp_o   (s_bresp_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i)
  );

endmodule

// File: verification/plic_chk.sv
// Reset and AXI response stability checks bound into plic_top; one outstanding transaction
`timescale 1ns/1ns

module plic_chk import plic_pkg::*; (
  input logic                   clk_i,
  input logic                   rst_i,
  input logic                   irq_o,
  input logic [AXIL_DATA_W-1:0] s_rdata_o,
  input logic [1:0]             s_rresp_o,
  input logic                   s_rvalid_o,
  input logic                   s_rready_i,
  input logic [1:0]             s_bresp_o,
  input logic                   s_bvalid_o,
  input logic                   s_bready_i
);

  //////////////////////////////////////////////////
  // Reset
  //////////////////////////////////////////////////

  // The winner register clears on reset, so the line is low right after it
  irq_after_reset: assert property (@(posedge clk_i) rst_i |=> !irq_o)
    else $error("irq_o high in the cycle after reset");

  //////////////////////////////////////////////////
  // Response channels under back-pressure
  //////////////////////////////////////////////////

  // A read response waits unchanged until the master takes it
  rdata_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (s_rvalid_o && !s_rready_i) |=> (s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o)))
    else $error("read response changed while RREADY was low");

  // Same rule on the write response
  bresp_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (s_bvalid_o && !s_bready_i) |=> (s_bvalid_o && $stable(s_bresp_o)))
    else $error("write response changed while BREADY was low");

endmodule

bind plic_top plic_chk u_plic_chk (.*);

// File: verification/plic_tb.sv
// Testbench for plic_top with 8 sources and 3-bit priorities; sources driven synchronous to clk_i
`timescale 1ns/1ns

module plic_tb import plic_pkg::*; ();

  localparam int NumSrc        = 8;
  localparam int PrioWidth     = 3;
  localparam int IdWidth       = $clog2(NumSrc + 1);
  // All tests together need roughly 2000 cycles, so this leaves a wide margin
  localparam int TimeoutCycles = 20000;
  localparam logic [31:0] Seed = 32'h231d;

  logic                   clk_i = 1'b0;
  logic                   rst_i;
  logic [NumSrc-1:0]      src_i;
  logic                   irq_o;
  logic [AXIL_ADDR_W-1:0] s_awaddr_i;
  logic                   s_awvalid_i;
  logic                   s_awready_o;
  logic [AXIL_DATA_W-1:0] s_wdata_i;
  logic                   s_wvalid_i;
  logic                   s_wready_o;
  logic [1:0]             s_bresp_o;
  logic                   s_bvalid_o;
  logic                   s_bready_i;
  logic [AXIL_ADDR_W-1:0] s_araddr_i;
  logic                   s_arvalid_i;
  logic                   s_arready_o;
  logic [AXIL_DATA_W-1:0] s_rdata_o;
  logic [1:0]             s_rresp_o;
  logic                   s_rvalid_o;
  logic                   s_rready_i;

  // Mirror of the controller state, updated at the edge where the DUT changes
  logic [NumSrc-1:0][PrioWidth-1:0] prio_m;
  logic [NumSrc-1:0]                enable_m;
  logic [PrioWidth-1:0]             thr_m;
  logic [NumSrc-1:0]                src_m;
  logic [NumSrc-1:0]                pend_m;
  logic [NumSrc-1:0]                insvc_m;

  int    change_seq = 0;
  int    seen_seq   = 0;
  int    quiet      = 0;
  int    err_cnt    = 0;
  int    check_cnt  = 0;
  int    cycle_cnt  = 0;
  int    test_base;
  string test_name;

  always #2 clk_i = ~clk_i;

  plic_top #(.NumSrc(NumSrc), .PrioWidth(PrioWidth)) u_plic_top (.*);

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Lowest ID with the highest priority above the threshold
  function automatic logic [IdWidth-1:0] ref_claim(input logic [NumSrc-1:0] pend,
      input logic [NumSrc-1:0] en, input logic [NumSrc-1:0][PrioWidth-1:0] pr,
      input logic [PrioWidth-1:0] thr);
    logic [IdWidth-1:0]   best;
    logic [PrioWidth-1:0] best_p;
    best   = '0;
    best_p = thr;
    for (int i = 0; i < NumSrc; i++) begin
      // Strictly greater keeps the earlier, lower ID on a tie
      if (pend[i] && en[i] && (pr[i] != '0) && (pr[i] > best_p)) begin
        best   = IdWidth'(i + 1);
        best_p = pr[i];
      end
    end
    return best;
  endfunction

  function automatic logic addr_mapped(input logic [AXIL_ADDR_W-1:0] addr);
    if (addr[1:0] != 2'b00) return 1'b0;
    if (addr < PRIO_BASE + AXIL_ADDR_W'(4 * NumSrc)) return 1'b1;
    return (addr == PENDING_ADDR) || (addr == ENABLE_ADDR) ||
           (addr == THRESHOLD_ADDR) || (addr == CLAIM_ADDR);
  endfunction

  function automatic logic [AXIL_ADDR_W-1:0] prio_addr(input int idx);
    return PRIO_BASE + AXIL_ADDR_W'(4 * idx);
  endfunction

  function automatic logic [AXIL_DATA_W-1:0] expected_read(input logic [AXIL_ADDR_W-1:0] addr);
    if (!addr_mapped(addr)) return '0;
    case (addr)
      PENDING_ADDR:   return AXIL_DATA_W'(pend_m);
      ENABLE_ADDR:    return AXIL_DATA_W'(enable_m);
      THRESHOLD_ADDR: return AXIL_DATA_W'(thr_m);
      CLAIM_ADDR:     return AXIL_DATA_W'(ref_claim(pend_m, enable_m, prio_m, thr_m));
      default:        return AXIL_DATA_W'(prio_m[addr[2 +: 3]]);
    endcase
  endfunction

  function automatic void mirror_write(input logic [AXIL_ADDR_W-1:0] addr,
                                       input logic [AXIL_DATA_W-1:0] data);
    logic [IdWidth-1:0] id;
    id = data[IdWidth-1:0];
    if (!addr_mapped(addr)) return;
    case (addr)
      PENDING_ADDR:   ;
      ENABLE_ADDR:    enable_m = data[NumSrc-1:0];
      THRESHOLD_ADDR: thr_m    = data[PrioWidth-1:0];
      CLAIM_ADDR: begin
        // A complete frees the source, which re-pends if its level is still high
        if ((id != '0) && (id <= IdWidth'(NumSrc)) && insvc_m[id-1'b1]) begin
          insvc_m[id-1'b1] = 1'b0;
          pend_m = pend_m | (src_m & ~insvc_m);
        end
      end
      default:        prio_m[addr[2 +: 3]] = data[PrioWidth-1:0];
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Compare, bus and source tasks
  //////////////////////////////////////////////////

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL t=%0t %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic axi_write(input logic [AXIL_ADDR_W-1:0] addr, input logic [AXIL_DATA_W-1:0] data,
                           input int hold, output logic [1:0] resp);
    @(posedge clk_i);
    s_awaddr_i  <= addr;
    s_awvalid_i <= 1'b1;
    s_wdata_i   <= data;
    s_wvalid_i  <= 1'b1;
    @(negedge clk_i);
    while (!s_awready_o) @(negedge clk_i);
    // Both write channels are taken in the same cycle
    check("wready with awready", 32'(s_wready_o), 32'd1);
    // Acceptance edge, the register changes here too
    @(posedge clk_i);
    s_awvalid_i <= 1'b0;
    s_wvalid_i  <= 1'b0;
    mirror_write(addr, data);
    change_seq++;
    repeat (hold) @(posedge clk_i);
    s_bready_i <= 1'b1;
    @(negedge clk_i);
    while (!s_bvalid_o) @(negedge clk_i);
    resp = s_bresp_o;
    @(posedge clk_i);
    s_bready_i <= 1'b0;
  endtask

  task automatic axi_read(input logic [AXIL_ADDR_W-1:0] addr, input int hold,
                          output logic [AXIL_DATA_W-1:0] data, output logic [1:0] resp,
                          output logic [AXIL_DATA_W-1:0] exp);
    int idx;
    @(posedge clk_i);
    s_araddr_i  <= addr;
    s_arvalid_i <= 1'b1;
    @(negedge clk_i);
    while (!s_arready_o) @(negedge clk_i);
    @(posedge clk_i);
    s_arvalid_i <= 1'b0;
    exp = expected_read(addr);
    // A claim moves the winner from pending to in service at acceptance
    if ((addr == CLAIM_ADDR) && (exp != '0)) begin
      idx = int'(exp) - 1;
      pend_m[idx]  = 1'b0;
      insvc_m[idx] = 1'b1;
      change_seq++;
    end
    repeat (hold) @(posedge clk_i);
    s_rready_i <= 1'b1;
    @(negedge clk_i);
    while (!s_rvalid_o) @(negedge clk_i);
    data = s_rdata_o;
    resp = s_rresp_o;
    @(posedge clk_i);
    s_rready_i <= 1'b0;
  endtask

  task automatic write_check(input string what, input logic [AXIL_ADDR_W-1:0] addr,
                             input logic [AXIL_DATA_W-1:0] data, input int hold);
    logic [1:0] resp;
    axi_write(addr, data, hold, resp);
    check({what, " resp"}, 32'(resp), 32'(addr_mapped(addr) ? RESP_OKAY : RESP_SLVERR));
  endtask

  task automatic read_check(input string what, input logic [AXIL_ADDR_W-1:0] addr,
                            input int hold, output logic [AXIL_DATA_W-1:0] data);
    logic [1:0]             resp;
    logic [AXIL_DATA_W-1:0] exp;
    axi_read(addr, hold, data, resp, exp);
    check({what, " data"}, data, exp);
    check({what, " resp"}, 32'(resp), 32'(addr_mapped(addr) ? RESP_OKAY : RESP_SLVERR));
  endtask

  task automatic set_sources(input logic [NumSrc-1:0] val);
    @(posedge clk_i);
    src_i <= val;
    src_m  = val;
    pend_m = pend_m | (val & ~insvc_m);
    change_seq++;
  endtask

  task automatic settle();
    repeat (3) @(negedge clk_i);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_base = err_cnt;
  endtask

  task automatic end_test();
    $display("test %-24s %0d mismatches", test_name, err_cnt - test_base);
  endtask

  // irq_o is compared once two edges have passed since the last mirror change
  always @(negedge clk_i) begin
    if (rst_i || (change_seq != seen_seq)) begin
      seen_seq = change_seq;
      quiet    = 0;
    end else begin
      if (quiet < 2) quiet++;
      if (quiet >= 2) begin
        check("irq_o", 32'(irq_o), 32'(ref_claim(pend_m, enable_m, prio_m, thr_m) != '0));
      end
    end
  end

  // Watchdog
  initial begin
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", TimeoutCycles);
    $display("sim failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    int                     dummy;
    int                     s;
    logic [AXIL_DATA_W-1:0] rd;
    dummy = $urandom(Seed);
    rst_i       <= 1'b1;
    src_i       <= '0;
    s_awaddr_i  <= '0;
    s_awvalid_i <= 1'b0;
    s_wdata_i   <= '0;
    s_wvalid_i  <= 1'b0;
    s_bready_i  <= 1'b0;
    s_araddr_i  <= '0;
    s_arvalid_i <= 1'b0;
    s_rready_i  <= 1'b0;
    prio_m   = '0;
    enable_m = '0;
    thr_m    = '0;
    src_m    = '0;
    pend_m   = '0;
    insvc_m  = '0;
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;

    start_test("register readback");
    for (int i = 0; i < NumSrc; i++) write_check("prio", prio_addr(i), 32'($urandom_range(7)), 0);
    write_check("enable", ENABLE_ADDR, 32'($urandom_range(255)), 0);
    write_check("threshold", THRESHOLD_ADDR, 32'($urandom_range(7)), 0);
    for (int i = 0; i < NumSrc; i++) read_check("prio", prio_addr(i), 0, rd);
    read_check("enable", ENABLE_ADDR, 0, rd);
    read_check("threshold", THRESHOLD_ADDR, 0, rd);
    set_sources(NumSrc'($urandom_range(255)));
    settle();
    read_check("pending", PENDING_ADDR, 0, rd);
    end_test();

    start_test("arbitration");
    for (int r = 0; r < 30; r++) begin
      for (int i = 0; i < NumSrc; i++) write_check("prio", prio_addr(i), 32'($urandom_range(7)), 0);
      write_check("enable", ENABLE_ADDR, 32'($urandom_range(255)), 0);
      write_check("threshold", THRESHOLD_ADDR, 32'($urandom_range(2)), 0);
      set_sources(NumSrc'($urandom_range(255)));
      settle();
      read_check("claim", CLAIM_ADDR, 0, rd);
      if (rd != 0) write_check("complete", CLAIM_ADDR, rd, 0);
    end
    // Equal priorities everywhere, so only the lowest ID may win
    for (int i = 0; i < NumSrc; i++) write_check("prio", prio_addr(i), 32'd5, 0);
    write_check("enable", ENABLE_ADDR, 32'hFF, 0);
    set_sources(8'hA4);
    settle();
    read_check("tie claim", CLAIM_ADDR, 0, rd);
    if (rd != 0) write_check("complete", CLAIM_ADDR, rd, 0);
    end_test();

    start_test("threshold and prio zero");
    write_check("threshold", THRESHOLD_ADDR, 32'd7, 0);
    set_sources(8'hFF);
    settle();
    read_check("claim", CLAIM_ADDR, 0, rd);
    check("claim at max threshold", rd, 32'd0);
    write_check("threshold", THRESHOLD_ADDR, 32'd4, 0);
    for (int i = 0; i < NumSrc; i++) write_check("prio", prio_addr(i), 32'($urandom_range(4)), 0);
    settle();
    check("irq low at threshold", 32'(irq_o), 32'd0);
    read_check("claim", CLAIM_ADDR, 0, rd);
    check("claim at threshold", rd, 32'd0);
    write_check("threshold", THRESHOLD_ADDR, 32'd0, 0);
    for (int i = 0; i < NumSrc; i++) write_check("prio", prio_addr(i), 32'd0, 0);
    settle();
    check("irq low with prio 0", 32'(irq_o), 32'd0);
    read_check("claim", CLAIM_ADDR, 0, rd);
    check("claim with prio 0", rd, 32'd0);
    end_test();

    start_test("claim and complete");
    s = int'($urandom_range(NumSrc - 1));
    for (int i = 0; i < NumSrc; i++) begin
      write_check("prio", prio_addr(i), (i == s) ? 32'd7 : 32'd1, 0);
    end
    set_sources(NumSrc'(1 << s));
    settle();
    read_check("claim", CLAIM_ADDR, 0, rd);
    check("claimed id", rd, 32'(s + 1));
    settle();
    // Level still high, yet the source must stay out of pending while in service
    read_check("pending", PENDING_ADDR, 0, rd);
    check("pending while in service", 32'(rd[s]), 32'd0);
    write_check("complete", CLAIM_ADDR, 32'(s + 1), 0);
    settle();
    read_check("pending", PENDING_ADDR, 0, rd);
    check("pending after complete", 32'(rd[s]), 32'd1);
    read_check("claim", CLAIM_ADDR, 0, rd);
    check("reclaimed id", rd, 32'(s + 1));
    set_sources('0);
    write_check("complete", CLAIM_ADDR, 32'(s + 1), 0);
    settle();
    read_check("pending", PENDING_ADDR, 0, rd);
    check("pending after low complete", 32'(rd[s]), 32'd0);
    end_test();

    start_test("errors and back-pressure");
    read_check("unmapped", 12'h300, 0, rd);
    read_check("unmapped", 12'h0FC, 0, rd);
    read_check("misaligned", 12'h102, 0, rd);
    write_check("unmapped", 12'h3F0, 32'h5, 0);
    for (int r = 0; r < 10; r++) begin
      write_check("threshold", THRESHOLD_ADDR, 32'($urandom_range(7)),
                  int'($urandom_range(1, 8)));
      read_check("threshold", THRESHOLD_ADDR, int'($urandom_range(1, 8)), rd);
      read_check("prio", prio_addr(int'($urandom_range(NumSrc - 1))),
                 int'($urandom_range(1, 8)), rd);
      read_check("unmapped", 12'h300, int'($urandom_range(1, 8)), rd);
      write_check("unmapped", 12'h3F0, 32'h1, int'($urandom_range(1, 8)));
    end
    end_test();

    $display("checks %0d, mismatches %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: plic_top.f
verilog/plic_pkg.sv
verilog/plic_cfg_if.sv
verilog/plic_max_tree.sv
verilog/plic_gateway.sv
verilog/plic_target.sv
verilog/plic_axil_regs.sv
verilog/plic_top.sv
verification/plic_chk.sv
verification/plic_tb.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := plic_tb
FILELIST  := plic_top.f
BUILD_DIR := obj_dir
PASS_MSG  := sim passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only when the testbench prints the pass message
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
